// ==== hw/mips_pkg.sv ====
package mips_pkg;

	// datapath widths
	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	// first fetch address out of reset
	localparam logic [XLEN-1:0] RESET_VECTOR = 32'hbfc00000;

	// primary opcodes, inst[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_SW      = 6'b101011;

	// special function codes, inst[5:0]
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_t;

	// second alu operand
	typedef enum logic [1:0] {B_REG, B_SIMM, B_ZIMM, B_UIMM} b_src_t;

	// register write data source
	typedef enum logic {WB_ALU, WB_MEM} wb_src_t;

	// destination register field
	typedef enum logic {DST_RT, DST_RD} dst_sel_t;

endpackage

// ==== hw/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit import mips_pkg::*;
(
	input  logic            clk,
	input  logic            resetn,
	input  logic            redirect,
	input  logic [XLEN-1:0] redirect_target,
	input  logic [XLEN-1:0] inst_rdata,
	output logic [XLEN-1:0] inst_addr,
	output logic [XLEN-1:0] id_inst,
	output logic [XLEN-1:0] id_pc,
	output logic            id_valid
);

	// sram returns the word one cycle after the address
	// so the returning word belongs to id_pc
	assign id_inst = inst_rdata;

	// next fetch address
	// redirect comes from the branch or jump now in execute,
	// whose delay slot is the instruction sitting in id
	always_comb
	begin
		if (!resetn)
			inst_addr = RESET_VECTOR;
		else if (redirect)
			inst_addr = redirect_target;
		else
			inst_addr = id_pc + XLEN'(4);
	end

	// id pc follows the fetch address every cycle
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			// one word below the vector, so the first fetch
			// after reset is the vector itself
			id_pc <= RESET_VECTOR - XLEN'(4);
			id_valid <= 1'b0;
		end
		else
		begin
			id_pc <= inst_addr;
			id_valid <= 1'b1;
		end
	end

	// every target the core can form is a word address
	a_id_pc_aligned: assert property (@(posedge clk) disable iff (!resetn)
		id_pc[1:0] == 2'b00);

endmodule

// ==== hw/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder import mips_pkg::*;
(
	input  logic [XLEN-1:0] inst,
	output alu_op_t         alu_op,
	output b_src_t          b_src,
	output logic            shamt_sel,
	output dst_sel_t        dst_sel,
	output logic            reg_write,
	output wb_src_t         wb_src,
	output logic            mem_read,
	output logic            mem_write,
	output logic            is_beq,
	output logic            is_bne,
	output logic            is_j
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = inst[31:26];
	assign funct = inst[5:0];

	always_comb
	begin
		// defaults form a no-op
		alu_op = ALU_ADD;
		b_src = B_REG;
		shamt_sel = 1'b0;
		dst_sel = DST_RT;
		reg_write = 1'b0;
		wb_src = WB_ALU;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_j = 1'b0;
		case (opcode)
			OP_SPECIAL:
			begin
				dst_sel = DST_RD;
				reg_write = 1'b1;
				// constant shifts take the amount from inst[10:6]
				shamt_sel = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);
				case (funct)
					FN_SLL: alu_op = ALU_SLL;
					FN_SRL: alu_op = ALU_SRL;
					FN_SRA: alu_op = ALU_SRA;
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR: alu_op = ALU_OR;
					FN_XOR: alu_op = ALU_XOR;
					FN_NOR: alu_op = ALU_NOR;
					FN_SLT: alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					// unknown function, nothing written
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDIU, OP_SLTI:
			begin
				alu_op = (opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
				b_src = B_SIMM;
				reg_write = 1'b1;
			end
			OP_ANDI, OP_ORI, OP_XORI:
			begin
				alu_op = (opcode == OP_ANDI) ? ALU_AND :
					(opcode == OP_ORI) ? ALU_OR : ALU_XOR;
				b_src = B_ZIMM;
				reg_write = 1'b1;
			end
			OP_LUI:
			begin
				// rs operand is forced to zero in execute
				alu_op = ALU_OR;
				b_src = B_UIMM;
				reg_write = 1'b1;
			end
			OP_LW:
			begin
				b_src = B_SIMM;
				reg_write = 1'b1;
				wb_src = WB_MEM;
				mem_read = 1'b1;
			end
			OP_SW:
			begin
				b_src = B_SIMM;
				mem_write = 1'b1;
			end
			// compare by subtract, alu zero flag decides
			OP_BEQ:
			begin
				alu_op = ALU_SUB;
				is_beq = 1'b1;
			end
			OP_BNE:
			begin
				alu_op = ALU_SUB;
				is_bne = 1'b1;
			end
			OP_J: is_j = 1'b1;
			default: reg_write = 1'b0;
		endcase
	end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/100ps

module reg_file import mips_pkg::*;
(
	input  logic                  clk,
	input  logic [REG_ADDR_W-1:0] raddr1,
	input  logic [REG_ADDR_W-1:0] raddr2,
	output logic [XLEN-1:0]       rdata1,
	output logic [XLEN-1:0]       rdata2,
	input  logic                  wen,
	input  logic [REG_ADDR_W-1:0] waddr,
	input  logic [XLEN-1:0]       wdata
);

	logic [XLEN-1:0] regs [2**REG_ADDR_W];

	// single write port
	// writes to $0 land in regs[0] but are never seen
	always_ff @(posedge clk)
	begin
		if (wen)
			regs[waddr] <= wdata;
	end

	// async reads, $0 hardwired to zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/100ps

module alu import mips_pkg::*;
(
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  alu_op_t         op,
	output logic [XLEN-1:0] result,
	output logic            zero
);

	logic [4:0] shamt;

	// shift amount comes in on operand a
	assign shamt = a[4:0];

	always_comb
	begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_SLT: result = XLEN'($signed(a) < $signed(b));
			ALU_SLTU: result = XLEN'(a < b);
			// shifted value is operand b
			ALU_SLL: result = b << shamt;
			ALU_SRL: result = b >> shamt;
			ALU_SRA: result = $unsigned($signed(b) >>> shamt);
			default: result = '0;
		endcase
	end

	// used by beq/bne after a subtract
	assign zero = (result == '0);

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage import mips_pkg::*;
(
	input  logic                  clk,
	input  logic                  resetn,
	input  logic [XLEN-1:0]       id_inst,
	input  logic [XLEN-1:0]       id_pc,
	input  logic                  id_valid,
	input  logic                  wb_wen,
	input  logic [REG_ADDR_W-1:0] wb_waddr,
	input  logic [XLEN-1:0]       wb_wdata,
	output logic                  redirect,
	output logic [XLEN-1:0]       redirect_target,
	output logic                  mem_en,
	output logic [3:0]            mem_wen,
	output logic [XLEN-1:0]       mem_addr,
	output logic [XLEN-1:0]       mem_wdata,
	output logic                  ex_valid,
	output logic [XLEN-1:0]       ex_pc,
	output logic [REG_ADDR_W-1:0] ex_waddr,
	output logic                  ex_wen,
	output wb_src_t               ex_wb_src,
	output logic [XLEN-1:0]       ex_result
);

	// decoder outputs in id
	alu_op_t id_alu_op;
	b_src_t id_b_src;
	logic id_shamt_sel;
	dst_sel_t id_dst_sel;
	logic id_reg_write;
	wb_src_t id_wb_src;
	logic id_mem_read;
	logic id_mem_write;
	logic id_is_beq;
	logic id_is_bne;
	logic id_is_j;

	// id/ex register
	logic [XLEN-1:0] ex_inst;
	alu_op_t ex_alu_op;
	b_src_t ex_b_src;
	logic ex_shamt_sel;
	dst_sel_t ex_dst_sel;
	logic ex_reg_write;
	logic ex_mem_read;
	logic ex_mem_write;
	logic ex_is_beq;
	logic ex_is_bne;
	logic ex_is_j;

	logic [REG_ADDR_W-1:0] ex_rs;
	logic [REG_ADDR_W-1:0] ex_rt;
	logic [15:0] ex_imm;
	logic [XLEN-1:0] rf_rdata1;
	logic [XLEN-1:0] rf_rdata2;
	logic [XLEN-1:0] rs_val;
	logic [XLEN-1:0] rt_val;
	logic [XLEN-1:0] alu_a;
	logic [XLEN-1:0] alu_b;
	logic alu_zero;
	logic [XLEN-1:0] pc_plus4;
	logic br_taken;

	inst_decoder decoder_i (
		.inst(id_inst),
		.alu_op(id_alu_op),
		.b_src(id_b_src),
		.shamt_sel(id_shamt_sel),
		.dst_sel(id_dst_sel),
		.reg_write(id_reg_write),
		.wb_src(id_wb_src),
		.mem_read(id_mem_read),
		.mem_write(id_mem_write),
		.is_beq(id_is_beq),
		.is_bne(id_is_bne),
		.is_j(id_is_j)
	);

	// loads every cycle and never stalls
	always_ff @(posedge clk)
	begin
		if (!resetn)
			ex_valid <= 1'b0;
		else
			ex_valid <= id_valid;
		ex_pc <= id_pc;
		ex_inst <= id_inst;
		ex_alu_op <= id_alu_op;
		ex_b_src <= id_b_src;
		ex_shamt_sel <= id_shamt_sel;
		ex_dst_sel <= id_dst_sel;
		ex_reg_write <= id_reg_write;
		ex_wb_src <= id_wb_src;
		ex_mem_read <= id_mem_read;
		ex_mem_write <= id_mem_write;
		ex_is_beq <= id_is_beq;
		ex_is_bne <= id_is_bne;
		ex_is_j <= id_is_j;
	end

	assign ex_rs = ex_inst[25:21];
	assign ex_rt = ex_inst[20:16];
	assign ex_imm = ex_inst[15:0];

	// write port comes back from writeback
	reg_file rf_i (
		.clk(clk),
		.raddr1(ex_rs),
		.raddr2(ex_rt),
		.rdata1(rf_rdata1),
		.rdata2(rf_rdata2),
		.wen(wb_wen),
		.waddr(wb_waddr),
		.wdata(wb_wdata)
	);

	// bypass from the instruction one ahead including load data
	assign rs_val = (wb_wen && wb_waddr == ex_rs && ex_rs != '0) ? wb_wdata : rf_rdata1;
	assign rt_val = (wb_wen && wb_waddr == ex_rt && ex_rt != '0) ? wb_wdata : rf_rdata2;

	// lui ors the upper immediate onto zero instead of rs
	assign alu_a = ex_shamt_sel ? XLEN'(ex_inst[10:6]) :
		(ex_b_src == B_UIMM) ? '0 : rs_val;

	always_comb
	begin
		case (ex_b_src)
			B_SIMM: alu_b = {{16{ex_imm[15]}}, ex_imm};
			B_ZIMM: alu_b = {16'b0, ex_imm};
			B_UIMM: alu_b = {ex_imm, 16'b0};
			default: alu_b = rt_val;
		endcase
	end

	alu alu_i (
		.a(alu_a),
		.b(alu_b),
		.op(ex_alu_op),
		.result(ex_result),
		.zero(alu_zero)
	);

	// control transfer with the delay slot already in id
	assign pc_plus4 = ex_pc + XLEN'(4);
	assign br_taken = (ex_is_beq && alu_zero) || (ex_is_bne && !alu_zero);
	assign redirect = ex_valid && (br_taken || ex_is_j);
	assign redirect_target = ex_is_j ? {pc_plus4[31:28], ex_inst[25:0], 2'b00} :
		pc_plus4 + {{14{ex_imm[15]}}, ex_imm, 2'b00};

	// data sram request for word accesses only
	assign mem_en = ex_valid && (ex_mem_read || ex_mem_write);
	assign mem_wen = {4{ex_valid && ex_mem_write}};
	assign mem_addr = ex_result;
	assign mem_wdata = rt_val;

	// $0 never reaches the write port
	assign ex_waddr = (ex_dst_sel == DST_RD) ? ex_inst[15:11] : ex_rt;
	assign ex_wen = ex_valid && ex_reg_write && (ex_waddr != '0);

	// a memory access never redirects and a store never writes a register
	a_mem_no_redirect: assert property (@(posedge clk) disable iff (!resetn)
		mem_en |-> !redirect);
	a_store_no_write: assert property (@(posedge clk) disable iff (!resetn)
		(mem_wen != '0) |-> !ex_wen);

endmodule

// ==== hw/writeback_stage.sv ====
`timescale 1ns/100ps

module writeback_stage import mips_pkg::*;
(
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  ex_valid,
	input  logic [XLEN-1:0]       ex_pc,
	input  logic [REG_ADDR_W-1:0] ex_waddr,
	input  logic                  ex_wen,
	input  wb_src_t               ex_wb_src,
	input  logic [XLEN-1:0]       ex_result,
	input  logic [XLEN-1:0]       mem_rdata,
	output logic                  wb_wen,
	output logic [REG_ADDR_W-1:0] wb_waddr,
	output logic [XLEN-1:0]       wb_wdata,
	output logic [XLEN-1:0]       debug_pc,
	output logic [3:0]            debug_wen,
	output logic [REG_ADDR_W-1:0] debug_wnum,
	output logic [XLEN-1:0]       debug_wdata
);

	// ex/wb register
	logic wb_valid;
	logic [XLEN-1:0] wb_pc;
	wb_src_t wb_src;
	logic [XLEN-1:0] wb_result;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			wb_valid <= 1'b0;
			wb_wen <= 1'b0;
		end
		else
		begin
			wb_valid <= ex_valid;
			wb_wen <= ex_wen;
		end
		wb_pc <= ex_pc;
		wb_waddr <= ex_waddr;
		wb_src <= ex_wb_src;
		wb_result <= ex_result;
	end

	// load data arrives from the sram in this cycle
	assign wb_wdata = (wb_src == WB_MEM) ? mem_rdata : wb_result;

	// trace of committed writes, one cycle behind the write port
	always_ff @(posedge clk)
	begin
		if (!resetn)
			debug_wen <= 4'b0;
		else
			debug_wen <= {4{wb_wen}};
		if (wb_wen)
		begin
			debug_pc <= wb_pc;
			debug_wnum <= wb_waddr;
			debug_wdata <= wb_wdata;
		end
	end

	// execute folds its valid into the write enable
	a_wen_valid: assert property (@(posedge clk) disable iff (!resetn)
		wb_wen |-> wb_valid);

endmodule

// ==== hw/mips_core.sv ====
`timescale 1ns/100ps

module mips_core import mips_pkg::*;
(
	input  logic                  clk,
	input  logic                  resetn,
	output logic                  inst_sram_en,
	output logic [3:0]            inst_sram_wen,
	output logic [XLEN-1:0]       inst_sram_addr,
	output logic [XLEN-1:0]       inst_sram_wdata,
	input  logic [XLEN-1:0]       inst_sram_rdata,
	output logic                  data_sram_en,
	output logic [3:0]            data_sram_wen,
	output logic [XLEN-1:0]       data_sram_addr,
	output logic [XLEN-1:0]       data_sram_wdata,
	input  logic [XLEN-1:0]       data_sram_rdata,
	output logic [XLEN-1:0]       debug_wb_pc,
	output logic [3:0]            debug_wb_rf_wen,
	output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum,
	output logic [XLEN-1:0]       debug_wb_rf_wdata
);

	// fetch to execute
	logic [XLEN-1:0] id_inst;
	logic [XLEN-1:0] id_pc;
	logic id_valid;
	logic redirect;
	logic [XLEN-1:0] redirect_target;

	// execute to writeback
	logic ex_valid;
	logic [XLEN-1:0] ex_pc;
	logic [REG_ADDR_W-1:0] ex_waddr;
	logic ex_wen;
	wb_src_t ex_wb_src;
	logic [XLEN-1:0] ex_result;

	// register write port back into execute
	logic wb_wen;
	logic [REG_ADDR_W-1:0] wb_waddr;
	logic [XLEN-1:0] wb_wdata;

	// instruction sram is read every cycle, never written
	assign inst_sram_en = 1'b1;
	assign inst_sram_wen = 4'b0;
	assign inst_sram_wdata = '0;

	fetch_unit fetch_i (
		.clk(clk),
		.resetn(resetn),
		.redirect(redirect),
		.redirect_target(redirect_target),
		.inst_rdata(inst_sram_rdata),
		.inst_addr(inst_sram_addr),
		.id_inst(id_inst),
		.id_pc(id_pc),
		.id_valid(id_valid)
	);

	execute_stage execute_i (
		.clk(clk),
		.resetn(resetn),
		.id_inst(id_inst),
		.id_pc(id_pc),
		.id_valid(id_valid),
		.wb_wen(wb_wen),
		.wb_waddr(wb_waddr),
		.wb_wdata(wb_wdata),
		.redirect(redirect),
		.redirect_target(redirect_target),
		.mem_en(data_sram_en),
		.mem_wen(data_sram_wen),
		.mem_addr(data_sram_addr),
		.mem_wdata(data_sram_wdata),
		.ex_valid(ex_valid),
		.ex_pc(ex_pc),
		.ex_waddr(ex_waddr),
		.ex_wen(ex_wen),
		.ex_wb_src(ex_wb_src),
		.ex_result(ex_result)
	);

	writeback_stage writeback_i (
		.clk(clk),
		.resetn(resetn),
		.ex_valid(ex_valid),
		.ex_pc(ex_pc),
		.ex_waddr(ex_waddr),
		.ex_wen(ex_wen),
		.ex_wb_src(ex_wb_src),
		.ex_result(ex_result),
		.mem_rdata(data_sram_rdata),
		.wb_wen(wb_wen),
		.wb_waddr(wb_waddr),
		.wb_wdata(wb_wdata),
		.debug_pc(debug_wb_pc),
		.debug_wen(debug_wb_rf_wen),
		.debug_wnum(debug_wb_rf_wnum),
		.debug_wdata(debug_wb_rf_wdata)
	);

endmodule

// ==== verif/tb_mips_model.svh ====
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// instruction encoders
function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
	input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
	return {OP_SPECIAL, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// absolute jump to rom word idx
function automatic logic [31:0] enc_j(input int idx);
	logic [31:0] addr;
	addr = RESET_VECTOR + 32'(4 * idx);
	return {OP_J, addr[27:2]};
endfunction

function automatic logic [4:0] rand_reg();
	return 5'($urandom);
endfunction

function automatic int dmem_index(input logic [31:0] addr);
	return int'(addr[9:2]);
endfunction

// random alu or immediate op reading src, dst sometimes $0
function automatic logic [31:0] random_op(input logic [4:0] src, output logic [4:0] dst);
	logic [5:0] fns [11];
	logic [5:0] ops [6];
	logic [5:0] fn;
	logic [31:0] r;
	fns = '{FN_SLL, FN_SRL, FN_SRA, FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
		FN_NOR, FN_SLT, FN_SLTU};
	ops = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
	dst = (($urandom % 8) == 0) ? 5'd0 : 5'($urandom % 31 + 1);
	if (($urandom % 2) == 0)
	begin
		fn = fns[$urandom % 11];
		// shifts take rt and the constant amount
		if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA)
			r = enc_r(fn, 5'd0, src, dst, 5'($urandom));
		else
			r = enc_r(fn, src, rand_reg(), dst, 5'd0);
	end
	else
		r = enc_i(ops[$urandom % 6], src, dst, 16'($urandom));
	return r;
endfunction

// random program at the reset vector, ends in a j-to-self with nop slot
function automatic void gen_program();
	int i;
	int k;
	int s;
	int kind;
	logic [4:0] last;
	logic [4:0] d;
	logic [4:0] rs;
	logic [15:0] off;
	for (k = 0; k < ROM_WORDS; k++)
		rom[k] = '0;
	// give every register a known value
	for (k = 1; k < 32; k++)
		rom[k-1] = enc_i(OP_ADDIU, 5'd0, 5'(k), 16'($urandom));
	i = 31;
	last = 5'd1;
	while (i < ROM_WORDS - 12)
	begin
		kind = int'($urandom % 10);
		off = DBASE + 16'(4 * ($urandom % 64));
		s = int'(1 + $urandom % 3);
		case (kind)
			5:
			begin
				// store, reload, then use at once
				rom[i] = enc_i(OP_SW, 5'd0, rand_reg(), off);
				d = 5'($urandom % 31 + 1);
				rom[i+1] = enc_i(OP_LW, 5'd0, d, off);
				rom[i+2] = random_op(d, d);
				i = i + 3;
			end
			6:
			begin
				d = 5'($urandom % 31 + 1);
				rom[i] = enc_i(OP_LW, 5'd0, d, off);
				rom[i+1] = random_op(d, d);
				i = i + 2;
			end
			7, 8, 9:
			begin
				rs = rand_reg();
				// equal operands force beq taken, bne untaken
				if (kind == 9)
					rom[i] = enc_j(i + 2 + s);
				else
					rom[i] = enc_i((kind == 7) ? OP_BEQ : OP_BNE, rs,
						(($urandom % 2) == 0) ? rs : rand_reg(), 16'(s + 1));
				// delay slot plus the skippable words
				for (k = 1; k <= s + 1; k++)
					rom[i+k] = random_op(rand_reg(), d);
				i = i + 2 + s;
			end
			default:
			begin
				rom[i] = random_op((($urandom % 2) == 0) ? last : rand_reg(), d);
				if (d != 5'd0)
					last = d;
				i = i + 1;
			end
		endcase
	end
	end_pc = RESET_VECTOR + 32'(4 * i);
	rom[i] = enc_j(i);
	rom[i+1] = '0;
endfunction

// architectural model with delay slots, fills the expected trace and stores
function automatic void run_model();
	logic [31:0] regs [32];
	logic [31:0] mem [DMEM_WORDS];
	logic [31:0] pc;
	logic [31:0] npc;
	logic [31:0] target;
	logic [31:0] inst;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] sext;
	logic [31:0] res;
	logic [4:0] wn;
	logic wr;
	int k;
	int steps;
	for (k = 0; k < 32; k++)
		regs[k] = '0;
	for (k = 0; k < DMEM_WORDS; k++)
		mem[k] = dmem_init[k];
	pc = RESET_VECTOR;
	npc = pc + 32'd4;
	steps = 0;
	while (pc != end_pc && steps < 4 * ROM_WORDS)
	begin
		inst = rom[int'((pc - RESET_VECTOR) >> 2)];
		a = regs[inst[25:21]];
		b = regs[inst[20:16]];
		sext = {{16{inst[15]}}, inst[15:0]};
		target = npc + 32'd4;
		wr = 1'b1;
		wn = inst[20:16];
		res = '0;
		case (inst[31:26])
			OP_SPECIAL:
			begin
				wn = inst[15:11];
				case (inst[5:0])
					FN_SLL: res = b << inst[10:6];
					FN_SRL: res = b >> inst[10:6];
					FN_SRA: res = $unsigned($signed(b) >>> inst[10:6]);
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND: res = a & b;
					FN_OR: res = a | b;
					FN_XOR: res = a ^ b;
					FN_NOR: res = ~(a | b);
					FN_SLT: res = {31'b0, $signed(a) < $signed(b)};
					FN_SLTU: res = {31'b0, a < b};
					default: wr = 1'b0;
				endcase
			end
			OP_ADDIU: res = a + sext;
			OP_SLTI: res = {31'b0, $signed(a) < $signed(sext)};
			OP_ANDI: res = a & {16'b0, inst[15:0]};
			OP_ORI: res = a | {16'b0, inst[15:0]};
			OP_XORI: res = a ^ {16'b0, inst[15:0]};
			OP_LUI: res = {inst[15:0], 16'b0};
			OP_LW: res = mem[dmem_index(a + sext)];
			OP_SW:
			begin
				wr = 1'b0;
				mem[dmem_index(a + sext)] = b;
				st_addr.push_back(a + sext);
				st_data.push_back(b);
			end
			default:
			begin
				wr = 1'b0;
				// branch offset counts from the delay slot
				if ((inst[31:26] == OP_BEQ && a == b) || (inst[31:26] == OP_BNE && a != b))
					target = npc + (sext << 2);
				if (inst[31:26] == OP_J)
					target = {npc[31:28], inst[25:0], 2'b00};
			end
		endcase
		if (wr && wn != 5'd0)
		begin
			regs[wn] = res;
			exp_pc.push_back(pc);
			exp_num.push_back(wn);
			exp_data.push_back(res);
		end
		pc = npc;
		npc = target;
		steps++;
	end
endfunction

`endif

// ==== verif/tb_mips_core.sv ====
`timescale 1ns/100ps

module tb_mips_core import mips_pkg::*;
();

	localparam int ROM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam logic [15:0] DBASE = 16'h0400;
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk = 1'b0;
	logic resetn = 1'b0;
	logic [31:0] inst_sram_rdata = '0;
	logic [31:0] data_sram_rdata = '0;
	logic inst_sram_en;
	logic [3:0] inst_sram_wen;
	logic [31:0] inst_sram_addr;
	logic [31:0] inst_sram_wdata;
	logic data_sram_en;
	logic [3:0] data_sram_wen;
	logic [31:0] data_sram_addr;
	logic [31:0] data_sram_wdata;
	logic [31:0] debug_wb_pc;
	logic [3:0] debug_wb_rf_wen;
	logic [4:0] debug_wb_rf_wnum;
	logic [31:0] debug_wb_rf_wdata;

	// program, data memory and expected results
	logic [31:0] rom [ROM_WORDS];
	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] dmem_init [DMEM_WORDS];
	logic [31:0] end_pc;
	logic [31:0] iaddr_q;
	logic [31:0] daddr_q;
	logic [31:0] exp_pc [$];
	logic [4:0] exp_num [$];
	logic [31:0] exp_data [$];
	logic [31:0] st_addr [$];
	logic [31:0] st_data [$];
	logic [31:0] e_pc;
	logic [4:0] e_num;
	logic [31:0] e_data;
	logic [31:0] e_addr;
	logic [31:0] e_sdata;
	int reset_checks = 0;
	int reset_errors = 0;
	int fetch_checks = 0;
	int fetch_errors = 0;
	int trace_checks = 0;
	int trace_errors = 0;
	int store_checks = 0;
	int store_errors = 0;
	int k;
	int cycles;
	logic timed_out;

	`include "tb_mips_model.svh"

	always #4 clk = ~clk;

	mips_core dut_i (
		.clk(clk),
		.resetn(resetn),
		.inst_sram_en(inst_sram_en),
		.inst_sram_wen(inst_sram_wen),
		.inst_sram_addr(inst_sram_addr),
		.inst_sram_wdata(inst_sram_wdata),
		.inst_sram_rdata(inst_sram_rdata),
		.data_sram_en(data_sram_en),
		.data_sram_wen(data_sram_wen),
		.data_sram_addr(data_sram_addr),
		.data_sram_wdata(data_sram_wdata),
		.data_sram_rdata(data_sram_rdata),
		.debug_wb_pc(debug_wb_pc),
		.debug_wb_rf_wen(debug_wb_rf_wen),
		.debug_wb_rf_wnum(debug_wb_rf_wnum),
		.debug_wb_rf_wdata(debug_wb_rf_wdata)
	);

	// sram models latch the address at the edge
	always @(posedge clk)
	begin
		if (inst_sram_en)
			iaddr_q <= inst_sram_addr;
		if (data_sram_en)
		begin
			daddr_q <= data_sram_addr;
			if (data_sram_wen != 4'b0)
				dmem[dmem_index(data_sram_addr)] = data_sram_wdata;
		end
	end

	// read data goes out on the falling edge one cycle after the address
	always @(negedge clk)
	begin
		if (!resetn || (iaddr_q - RESET_VECTOR) >= 32'(4 * ROM_WORDS))
			inst_sram_rdata <= '0;
		else
			inst_sram_rdata <= rom[int'((iaddr_q - RESET_VECTOR) >> 2)];
		data_sram_rdata <= resetn ? dmem[dmem_index(daddr_q)] : '0;
	end

	// compare fetch port, debug trace and stores against the model
	always @(negedge clk)
	begin
		if (resetn)
		begin
			// instruction sram is always read and never written
			fetch_checks++;
			assert (inst_sram_en == 1'b1) else
			begin
				$display("ERR inst_sram_en got %h exp 1", inst_sram_en);
				fetch_errors++;
			end
			assert (inst_sram_wen == 4'b0) else
			begin
				$display("ERR inst_sram_wen got %h exp 0", inst_sram_wen);
				fetch_errors++;
			end
			assert (inst_sram_wdata == 32'b0) else
			begin
				$display("ERR inst_sram_wdata got %h exp 0", inst_sram_wdata);
				fetch_errors++;
			end
		end
		if (resetn && debug_wb_rf_wen != 4'b0)
		begin
			if (exp_pc.size() == 0)
			begin
				$display("register write seen after the expected trace ran out");
				trace_errors++;
			end
			else
			begin
				e_pc = exp_pc.pop_front();
				e_num = exp_num.pop_front();
				e_data = exp_data.pop_front();
				trace_checks++;
				assert (debug_wb_rf_wen == 4'hf) else
				begin
					$display("ERR debug_wb_rf_wen got %h exp f", debug_wb_rf_wen);
					trace_errors++;
				end
				assert (debug_wb_pc == e_pc) else
				begin
					$display("ERR debug_wb_pc got %h exp %h", debug_wb_pc, e_pc);
					trace_errors++;
				end
				assert (debug_wb_rf_wnum == e_num) else
				begin
					$display("ERR debug_wb_rf_wnum got %h exp %h", debug_wb_rf_wnum, e_num);
					trace_errors++;
				end
				assert (debug_wb_rf_wdata == e_data) else
				begin
					$display("ERR debug_wb_rf_wdata got %h exp %h pc %h",
						debug_wb_rf_wdata, e_data, e_pc);
					trace_errors++;
				end
			end
		end
		if (resetn && data_sram_wen != 4'b0)
		begin
			if (st_addr.size() == 0)
			begin
				$display("store seen after the expected stores ran out");
				store_errors++;
			end
			else
			begin
				e_addr = st_addr.pop_front();
				e_sdata = st_data.pop_front();
				store_checks++;
				assert (data_sram_en) else
				begin
					$display("ERR data_sram_en got %h exp 1", data_sram_en);
					store_errors++;
				end
				assert (data_sram_wen == 4'hf) else
				begin
					$display("ERR data_sram_wen got %h exp f", data_sram_wen);
					store_errors++;
				end
				assert (data_sram_addr == e_addr) else
				begin
					$display("ERR data_sram_addr got %h exp %h", data_sram_addr, e_addr);
					store_errors++;
				end
				assert (data_sram_wdata == e_sdata) else
				begin
					$display("ERR data_sram_wdata got %h exp %h", data_sram_wdata, e_sdata);
					store_errors++;
				end
			end
		end
	end

	task automatic check_quiet();
		reset_checks++;
		assert (debug_wb_rf_wen == 4'b0) else
		begin
			$display("ERR debug_wb_rf_wen got %h exp 0", debug_wb_rf_wen);
			reset_errors++;
		end
		assert (data_sram_wen == 4'b0) else
		begin
			$display("ERR data_sram_wen got %h exp 0", data_sram_wen);
			reset_errors++;
		end
	endtask

	task automatic check_fetch_addr();
		reset_checks++;
		assert (inst_sram_addr == RESET_VECTOR) else
		begin
			$display("ERR inst_sram_addr got %h exp %h", inst_sram_addr, RESET_VECTOR);
			reset_errors++;
		end
	endtask

	initial
	begin
		void'($urandom(32'h153f));
		for (k = 0; k < DMEM_WORDS; k++)
		begin
			dmem[k] = $urandom;
			dmem_init[k] = dmem[k];
		end
		gen_program();
		run_model();
		$display("program ends at %h, %0d writes and %0d stores expected",
			end_pc, exp_pc.size(), st_addr.size());

		// reset held for five cycles
		for (k = 0; k < 5; k++)
		begin
			@(negedge clk);
			check_quiet();
			check_fetch_addr();
		end
		resetn = 1'b1;
		#1;
		check_fetch_addr();
		for (k = 0; k < 2; k++)
		begin
			@(negedge clk);
			check_quiet();
		end
		$display("reset: %0d checks, %0d errors", reset_checks, reset_errors);

		// run until the model's trace and stores are consumed
		cycles = 0;
		while ((exp_pc.size() != 0 || st_addr.size() != 0) && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			cycles++;
		end
		timed_out = (exp_pc.size() != 0 || st_addr.size() != 0);
		// the final loop must stay silent
		repeat (20) @(negedge clk);
		$display("fetch port: %0d checks, %0d errors", fetch_checks, fetch_errors);
		$display("write trace: %0d checks, %0d errors", trace_checks, trace_errors);
		$display("stores: %0d checks, %0d errors", store_checks, store_errors);
		$display("total: %0d checks, %0d errors",
			reset_checks + fetch_checks + trace_checks + store_checks,
			reset_errors + fetch_errors + trace_errors + store_errors);
		if (timed_out)
		begin
			$display("timed out with %0d writes and %0d stores still outstanding",
				exp_pc.size(), st_addr.size());
			$display("=== FAIL ===");
		end
		else if (reset_errors + fetch_errors + trace_errors + store_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+verif
hw/mips_pkg.sv
hw/fetch_unit.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/mips_core.sv
verif/tb_mips_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_mips_core -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "=== PASS ===" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
